//--- cam_pixel_packer.sv
// Camera byte qualifier and 4-byte word packer
// First byte of a word lands in the top byte
`timescale 1ns/1ps

module cam_pixel_packer (
	input  logic                      WBs_CLK_i,      // System clock
	input  logic                      WBs_RST_i,      // Async reset, high
	input  frame_stream_pkg::cam_in_t cam_i,          // Camera sample
	output frame_stream_pkg::word_t   pack_word_o,    // Packed word
	output logic                      pack_stb_o      // One cycle per word
);

	import frame_stream_pkg::*;

	localparam int BYTES_PER_WORD = WORD_W / PIX_W;
	localparam int CNT_W          = $clog2(BYTES_PER_WORD);
	localparam int HOLD_W         = WORD_W - PIX_W;    // Bytes kept before the last

	logic             byte_ok;     // Qualified byte this cycle
	logic             last_byte;   // Completes a word
	logic [CNT_W-1:0] byte_cnt;    // Bytes in the current word
	logic [HOLD_W-1:0] hold_sh;    // Earlier bytes of the word

	assign byte_ok   = cam_i.vsync & cam_i.href;
	assign last_byte = byte_ok && (byte_cnt == CNT_W'(BYTES_PER_WORD - 1));

	// ------------------------------
	// Byte count and strobe
	// ------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			byte_cnt   <= '0;
			pack_stb_o <= 1'b0;
		end else begin
			pack_stb_o <= last_byte;            // Strobe one clock after byte 4
			if (!cam_i.vsync)
				byte_cnt <= '0;                 // Partial word dropped at frame edge
			else if (byte_ok)
				byte_cnt <= byte_cnt + 1'b1;    // Wraps after the last byte
		end
	end

	// ------------------------------
	// Byte shifter
	// ------------------------------
	always_ff @(posedge WBs_CLK_i) begin
		if (byte_ok)
			hold_sh <= {hold_sh[HOLD_W-PIX_W-1:0], cam_i.data};    // Oldest byte moves up
		if (last_byte)
			pack_word_o <= {hold_sh, cam_i.data};                // Newest byte at the bottom
	end

endmodule

//--- cam_qspi_bridge.sv
// Top level of the camera to QSPI SRAM bridge
// Packer, ping-pong buffer, QSPI streamer and Wishbone status register
`timescale 1ns/1ps

module cam_qspi_bridge #(
	parameter int BANK_WORDS = 512    // Words per bank, power of two
) (
	input  logic                         WBs_CLK_i,    // System clock
	input  logic                         WBs_RST_i,    // Async reset, high
	input  frame_stream_pkg::cam_in_t    cam_i,        // Camera sample
	input  frame_stream_pkg::wb_req_t    wb_req_i,     // Wishbone request
	output frame_stream_pkg::word_t      wb_dat_o,     // Wishbone read data
	output logic                         wb_ack_o,     // Wishbone acknowledge
	output frame_stream_pkg::qspi_pins_t qspi_o        // SRAM pins
);

	import frame_stream_pkg::*;

	localparam int IDX_W = $clog2(BANK_WORDS);

	// ------------------------------
	// Pipeline links
	// ------------------------------
	word_t            pack_word;     // Packer to buffer
	logic             pack_stb;
	logic [IDX_W-1:0] rd_addr;       // Streamer to buffer
	word_t            rd_word;       // Buffer to streamer
	logic             bank_ready;
	logic             bank_done;
	logic             fill_bank;     // Status levels
	logic             overrun;
	logic             busy;
	logic             stream_en;     // Register controls
	logic             clr_overrun;
	status_t          status;

	assign status = '{
		stream_en: stream_en,
		overrun:   overrun,
		fill_bank: fill_bank,
		busy:      busy,
		vsync:     cam_i.vsync
	};

	cam_pixel_packer u_packer (
		.WBs_CLK_i   (WBs_CLK_i),
		.WBs_RST_i   (WBs_RST_i),
		.cam_i       (cam_i),
		.pack_word_o (pack_word),
		.pack_stb_o  (pack_stb)
	);

	frame_ping_pong_buffer #(.BANK_WORDS(BANK_WORDS)) u_buffer (
		.WBs_CLK_i     (WBs_CLK_i),
		.WBs_RST_i     (WBs_RST_i),
		.pack_word_i   (pack_word),
		.pack_stb_i    (pack_stb),
		.rd_addr_i     (rd_addr),
		.rd_word_o     (rd_word),
		.bank_ready_o  (bank_ready),
		.bank_done_i   (bank_done),
		.fill_bank_o   (fill_bank),
		.overrun_o     (overrun),
		.clr_overrun_i (clr_overrun)
	);

	qspi_write_streamer #(.BANK_WORDS(BANK_WORDS)) u_streamer (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.stream_en_i  (stream_en),
		.bank_ready_i (bank_ready),
		.rd_addr_o    (rd_addr),
		.rd_word_i    (rd_word),
		.bank_done_o  (bank_done),
		.busy_o       (busy),
		.qspi_o       (qspi_o)
	);

	wb_status_regs u_regs (
		.WBs_CLK_i     (WBs_CLK_i),
		.WBs_RST_i     (WBs_RST_i),
		.wb_req_i      (wb_req_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.status_i      (status),
		.stream_en_o   (stream_en),
		.clr_overrun_o (clr_overrun)
	);

endmodule

//--- frame_ping_pong_buffer.sv
// Two-bank word buffer between packer and QSPI streamer
// Bank fill and drain bookkeeping, sticky overrun flag
`timescale 1ns/1ps

module frame_ping_pong_buffer #(
	parameter int BANK_WORDS = 512    // Words per bank, power of two
) (
	input  logic                            WBs_CLK_i,        // System clock
	input  logic                            WBs_RST_i,        // Async reset, high
	input  frame_stream_pkg::word_t         pack_word_i,      // Word from packer
	input  logic                            pack_stb_i,       // Word valid
	input  logic [$clog2(BANK_WORDS)-1:0]   rd_addr_i,        // Word index in drain bank
	output frame_stream_pkg::word_t         rd_word_o,        // One cycle after rd_addr_i
	output logic                            bank_ready_o,     // Full bank waiting
	input  logic                            bank_done_i,      // Drain bank finished
	output logic                            fill_bank_o,      // Bank the camera writes
	output logic                            overrun_o,        // Words were dropped
	input  logic                            clr_overrun_i     // Clear strobe
);

	import frame_stream_pkg::*;

	localparam int IDX_W = $clog2(BANK_WORDS);

	word_t            mem [2*BANK_WORDS];    // Bank 0 low half, bank 1 high half
	logic [IDX_W-1:0] wr_idx;                // Next word in fill bank
	logic [1:0]       full;                  // Per-bank full flag
	logic             wr_bank;               // Fill bank
	logic             rd_bank;               // Oldest full bank
	logic             wr_en;                 // Word accepted
	logic             last_wr;               // Word closes the bank
	logic             other_free;            // Other bank empty, or emptied now
	logic             drop;                  // Word lost to a full bank

	assign wr_en      = pack_stb_i & ~full[wr_bank];
	assign drop       = pack_stb_i & full[wr_bank];
	assign last_wr    = wr_en && (wr_idx == IDX_W'(BANK_WORDS - 1));
	assign other_free = ~full[~wr_bank] | (bank_done_i & (rd_bank != wr_bank));

	assign bank_ready_o = full[rd_bank];
	assign fill_bank_o  = wr_bank;

	// ------------------------------
	// Bank bookkeeping
	// ------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wr_idx    <= '0;
			full      <= 2'b00;
			wr_bank   <= 1'b0;
			rd_bank   <= 1'b0;
			overrun_o <= 1'b0;
		end else begin
			if (bank_done_i) begin
				full[rd_bank] <= 1'b0;          // Free the drained bank
				rd_bank       <= ~rd_bank;      // Banks fill in turn
			end
			if (wr_en) begin
				wr_idx <= wr_idx + 1'b1;        // Back to 0 after the last word
				if (last_wr) begin
					full[wr_bank] <= 1'b1;
					if (other_free)
						wr_bank <= ~wr_bank;    // Swap on the next cycle
				end
			end else if (full[wr_bank] && other_free) begin
				wr_bank <= ~wr_bank;            // Resume after a stall
			end
			// Set wins over a clear in the same cycle
			if (clr_overrun_i)
				overrun_o <= 1'b0;
			if ((last_wr && !other_free) || drop)
				overrun_o <= 1'b1;
		end
	end

	// ------------------------------
	// Word storage
	// ------------------------------
	always_ff @(posedge WBs_CLK_i) begin
		if (wr_en)
			mem[{wr_bank, wr_idx}] <= pack_word_i;
		rd_word_o <= mem[{rd_bank, rd_addr_i}];    // Registered read
	end

endmodule

//--- frame_stream_pkg.sv
// Shared widths, QSPI constants and packed bus types
// for the camera to QSPI SRAM streaming bridge

package frame_stream_pkg;

	// ------------------------------
	// Widths
	// ------------------------------
	parameter int WORD_W      = 32;    // Buffered word
	parameter int PIX_W       = 8;     // One camera byte
	parameter int QSPI_ADDR_W = 24;    // SRAM byte address
	parameter int QSPI_NIB_W  = 4;     // Quad lane width
	parameter int WB_ADDR_W   = 11;    // Wishbone address space of the host bridge

	// ------------------------------
	// QSPI SRAM constants
	// ------------------------------
	parameter logic [7:0] QSPI_CMD_WRITE = 8'h38;    // Quad write, sent serially on DQ0

	// One buffered word
	typedef logic [WORD_W-1:0] word_t;

	// Camera sample, taken every clock
	typedef struct packed {
		logic             vsync;    // Frame active
		logic             href;     // Line active
		logic [PIX_W-1:0] data;     // Pixel byte
	} cam_in_t;

	// SRAM pins
	typedef struct packed {
		logic                  nce;    // Chip enable, low active
		logic                  oe;     // 1 = drive DQ
		logic [QSPI_NIB_W-1:0] dq;     // Quad data lines
	} qspi_pins_t;

	// Wishbone request from the host
	typedef struct packed {
		logic              cyc;         // Cycle valid
		logic              stb;         // Strobe
		logic              we;          // Write enable
		logic [3:0]        byte_sel;    // Byte lanes
		logic [WORD_W-1:0] dat;         // Write data
	} wb_req_t;

	// Status levels collected at the top
	typedef struct packed {
		logic stream_en;    // Control bit echo
		logic overrun;      // Sticky drop flag
		logic fill_bank;    // Bank the camera writes
		logic busy;         // Streamer mid transaction
		logic vsync;        // Raw camera vsync
	} status_t;

endpackage

//--- project.f
+incdir+.
frame_stream_pkg.sv
cam_pixel_packer.sv
frame_ping_pong_buffer.sv
qspi_write_streamer.sv
wb_status_regs.sv
cam_qspi_bridge.sv
tb_cam_qspi_bridge.sv

//--- qspi_write_streamer.sv
// QSPI SRAM write sequencer, one transaction per buffered word
// Command serial on DQ0, then address and data as nibbles
`timescale 1ns/1ps

module qspi_write_streamer #(
	parameter int BANK_WORDS = 512    // Words per bank, power of two
) (
	input  logic                            WBs_CLK_i,      // System clock
	input  logic                            WBs_RST_i,      // Async reset, high
	input  logic                            stream_en_i,    // Start new banks
	input  logic                            bank_ready_i,   // Full bank waiting
	output logic [$clog2(BANK_WORDS)-1:0]   rd_addr_o,      // Word index in bank
	input  frame_stream_pkg::word_t         rd_word_i,      // Word at rd_addr_o
	output logic                            bank_done_o,    // Last word of bank sent
	output logic                            busy_o,         // Transaction in flight
	output frame_stream_pkg::qspi_pins_t    qspi_o          // SRAM pins
);

	import frame_stream_pkg::*;

	localparam int IDX_W    = $clog2(BANK_WORDS);
	localparam int CMD_BITS = $bits(QSPI_CMD_WRITE);
	localparam int ADDR_NIB = QSPI_ADDR_W / QSPI_NIB_W;
	localparam int DATA_NIB = WORD_W / QSPI_NIB_W;

	typedef enum logic [2:0] {
		PH_IDLE,    // nCE high, waiting for a bank
		PH_CMD,     // Command bits on DQ0
		PH_ADDR,    // Address nibbles
		PH_DATA,    // Data nibbles
		PH_GAP      // One deselect cycle
	} phase_t;

	phase_t                 phase;       // Phase now on the pins
	logic [2:0]             cnt;         // Cycle within phase
	logic [CMD_BITS-1:0]    cmd_sh;      // Remaining command bits
	logic [QSPI_ADDR_W-1:0] addr_sh;     // Remaining address nibbles
	word_t                  data_sh;     // Remaining data nibbles
	logic [QSPI_ADDR_W-1:0] byte_addr;   // SRAM address of next word
	logic [IDX_W-1:0]       word_idx;    // Next word in bank
	logic                   launch;      // Begin a transaction

	assign rd_addr_o = word_idx;             // Held for the whole transaction
	assign busy_o    = (phase != PH_IDLE);

	// New bank from idle, or next word of the same bank after the gap
	assign launch = ((phase == PH_IDLE) && bank_ready_i && stream_en_i) ||
	                ((phase == PH_GAP) && (word_idx != '0));

	// ------------------------------
	// Phase sequencer
	// ------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			phase       <= PH_IDLE;
			cnt         <= '0;
			cmd_sh      <= '0;
			addr_sh     <= '0;
			data_sh     <= '0;
			byte_addr   <= '0;
			word_idx    <= '0;
			bank_done_o <= 1'b0;
			qspi_o.nce  <= 1'b1;     // Deselected
			qspi_o.oe   <= 1'b1;     // Output mode
			qspi_o.dq   <= '0;
		end else begin
			bank_done_o <= 1'b0;
			qspi_o.oe   <= 1'b1;     // Write only, never turns the bus
			if (launch) begin
				phase      <= PH_CMD;
				cnt        <= '0;
				qspi_o.nce <= 1'b0;
				qspi_o.dq  <= {3'b000, QSPI_CMD_WRITE[CMD_BITS-1]};    // MSB first
				cmd_sh     <= {QSPI_CMD_WRITE[CMD_BITS-2:0], 1'b0};
				addr_sh    <= byte_addr;
			end else begin
				case (phase)
					PH_CMD: begin
						if (cnt == 3'(CMD_BITS - 1)) begin
							phase     <= PH_ADDR;
							cnt       <= '0;
							qspi_o.dq <= addr_sh[QSPI_ADDR_W-1 -: QSPI_NIB_W];
							addr_sh   <= {addr_sh[QSPI_ADDR_W-QSPI_NIB_W-1:0], 4'h0};
						end else begin
							cnt       <= cnt + 1'b1;
							qspi_o.dq <= {3'b000, cmd_sh[CMD_BITS-1]};
							cmd_sh    <= {cmd_sh[CMD_BITS-2:0], 1'b0};
						end
					end
					PH_ADDR: begin
						if (cnt == 3'(ADDR_NIB - 1)) begin
							phase     <= PH_DATA;
							cnt       <= '0;
							qspi_o.dq <= rd_word_i[WORD_W-1 -: QSPI_NIB_W];        // Word read here
							data_sh   <= {rd_word_i[WORD_W-QSPI_NIB_W-1:0], 4'h0};
						end else begin
							cnt       <= cnt + 1'b1;
							qspi_o.dq <= addr_sh[QSPI_ADDR_W-1 -: QSPI_NIB_W];
							addr_sh   <= {addr_sh[QSPI_ADDR_W-QSPI_NIB_W-1:0], 4'h0};
						end
					end
					PH_DATA: begin
						if (cnt == 3'(DATA_NIB - 1)) begin
							phase      <= PH_GAP;
							cnt        <= '0;
							qspi_o.nce <= 1'b1;
							qspi_o.dq  <= '0;
							word_idx   <= word_idx + 1'b1;              // Wraps at bank end
							byte_addr  <= byte_addr + QSPI_ADDR_W'(4);  // Mod 2^24
							if (word_idx == '1)
								bank_done_o <= 1'b1;                    // Strobe during the gap
						end else begin
							cnt       <= cnt + 1'b1;
							qspi_o.dq <= data_sh[WORD_W-1 -: QSPI_NIB_W];
							data_sh   <= {data_sh[WORD_W-QSPI_NIB_W-1:0], 4'h0};
						end
					end
					PH_GAP:  phase <= PH_IDLE;     // Bank finished
					default: phase <= PH_IDLE;
				endcase
			end
		end
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the camera to QSPI bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f \
	--top-module tb_cam_qspi_bridge -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "RESULT: FAIL (build error)"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "RESULT: FAIL (simulator exit status $sim_status)"
	exit 1
fi

if grep -q "test failed" "$LOG"; then
	echo "RESULT: FAIL"
	exit 1
fi
if ! grep -q "test passed" "$LOG"; then
	echo "RESULT: FAIL (run ended without a verdict)"
	exit 1
fi

echo "RESULT: PASS"
exit 0

//--- tb_cam_qspi_tasks.svh
// Stimulus tasks, xorshift generator and reference word
// Included inside the testbench module
`ifndef TB_CAM_QSPI_TASKS_SVH
`define TB_CAM_QSPI_TASKS_SVH

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Expected SRAM word, earliest byte on top
	function automatic word_t ref_word(input logic [7:0] bytes [4]);
		word_t w;
		int    i;
		w = '0;
		for (i = 0; i < 4; i++)
			w = {w[23:0], bytes[i]};
		return w;
	endfunction

	// One valid byte, then href low for the rest of the gap
	task automatic send_byte(input int gap);
		logic [7:0] b;
		rng = xorshift32(rng);
		b   = rng[7:0];
		@(posedge WBs_CLK_i);
		cam <= '{vsync: 1'b1, href: 1'b1, data: b};
		cam_q.push_back(b);
		repeat (gap - 1) begin
			@(posedge WBs_CLK_i);
			cam <= '{vsync: 1'b1, href: 1'b0, data: b};
		end
	endtask

	// Single Wishbone access, ack expected one cycle after the strobe
	task automatic bus_cycle(input logic write, input word_t wdat, output word_t rdat);
		int wait_cyc;
		wait_cyc = 0;
		rdat     = '0;
		@(posedge WBs_CLK_i);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: write, byte_sel: 4'hf, dat: wdat};
		@(negedge WBs_CLK_i);
		while (!wb_ack && wait_cyc < 16) begin    // Bounded wait
			wait_cyc++;
			@(negedge WBs_CLK_i);
		end
		check_equal("wb_ack_o latency", 32'(wait_cyc), 32'd1);
		rdat = wb_dat;                            // Valid while ack high
		@(posedge WBs_CLK_i);
		wb_req <= '0;
		@(negedge WBs_CLK_i);
		check_equal("wb_ack_o after ack", 32'(wb_ack), 32'd0);
	endtask

`endif

//--- tb_cam_qspi_bridge.sv
// Testbench for the camera to QSPI SRAM bridge
// Clock, reset, DUT, QSPI monitor with reference compare, timeout
`timescale 1ns/1ps

module tb_cam_qspi_bridge;

	import frame_stream_pkg::*;

	localparam int BANK_WORDS  = 16;
	localparam int BYTE_GAP    = 8;    // Cycles per camera byte
	// Words over all tests: two banks, one bank, two banks plus one
	localparam int TOTAL_WORDS = 2 * BANK_WORDS + BANK_WORDS + 2 * BANK_WORDS + 1;
	localparam int TIMEOUT_CYC = 4 * TOTAL_WORDS * 4 * BYTE_GAP;    // About 4x camera time

	logic       WBs_CLK_i;
	logic       WBs_RST_i;
	cam_in_t    cam;        // Camera sample to DUT
	wb_req_t    wb_req;     // Wishbone request
	word_t      wb_dat;
	logic       wb_ack;
	qspi_pins_t qspi;       // SRAM pins from DUT

	logic [7:0]  cam_q [$];       // Bytes sent, not yet streamed
	logic [31:0] rng;             // Xorshift state
	int          err_cnt = 0;
	int          chk_cnt = 0;
	int          tests_bad = 0;
	int          cyc_cnt = 0;     // Timeout counter
	int          txn_cnt = 0;     // Transactions seen on the pins
	int          low_cnt = 0;     // nCE low cycles of current transaction
	logic [7:0]  cmd_got;
	logic [23:0] addr_got;
	word_t       data_got;

	cam_qspi_bridge #(.BANK_WORDS(BANK_WORDS)) cam_qspi_bridge_i (
		.WBs_CLK_i (WBs_CLK_i),
		.WBs_RST_i (WBs_RST_i),
		.cam_i     (cam),
		.wb_req_i  (wb_req),
		.wb_dat_o  (wb_dat),
		.wb_ack_o  (wb_ack),
		.qspi_o    (qspi)
	);

	always #50 WBs_CLK_i = ~WBs_CLK_i;    // 100 ns period

	task automatic check_equal(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		chk_cnt++;
		assert (got === exp) else begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic report_test(input int num, input string name, input int err_before);
		if (err_cnt != err_before)
			tests_bad++;
		$display("Test %0d %s: %0d errors", num, name, err_cnt - err_before);
	endtask

	`include "tb_cam_qspi_tasks.svh"

	// ------------------------------
	// QSPI monitor
	// ------------------------------
	task automatic check_txn();
		logic [7:0] bytes [4];
		int         i;
		chk_cnt++;
		assert (cam_q.size() >= 4) else begin
			$display("Error at %0t: transaction %0d sent with fewer than 4 camera bytes queued",
			         $time, txn_cnt);
			err_cnt++;
		end
		for (i = 0; i < 4; i++)
			bytes[i] = (cam_q.size() != 0) ? cam_q.pop_front() : 8'h00;    // Oldest first
		check_equal("qspi cmd", 32'(cmd_got), 32'(QSPI_CMD_WRITE));
		check_equal("qspi addr", 32'(addr_got), (4 * txn_cnt) & 32'h00ff_ffff);
		check_equal("qspi data", data_got, ref_word(bytes));
		check_equal("qspi nce low cycles", 32'(low_cnt), 32'd22);
		check_equal("qspi_o.oe", 32'(qspi.oe), 32'd1);
		txn_cnt++;
	endtask

	// Pins settle after the rising edge, sampled mid cycle
	always @(negedge WBs_CLK_i) begin
		if (WBs_RST_i) begin
			low_cnt = 0;
		end else if (!qspi.nce) begin
			if (low_cnt < 8)
				cmd_got = {cmd_got[6:0], qspi.dq[0]};     // Command serial on DQ0
			else if (low_cnt < 14)
				addr_got = {addr_got[19:0], qspi.dq};     // Six address nibbles
			else
				data_got = {data_got[27:0], qspi.dq};     // Eight data nibbles
			low_cnt++;
		end else if (low_cnt != 0) begin
			check_txn();                                  // nCE back high
			low_cnt = 0;
		end
	end

	always @(posedge WBs_CLK_i) begin
		cyc_cnt = cyc_cnt + 1;
		if (cyc_cnt >= TIMEOUT_CYC) begin
			$display("Timeout after %0d cycles, run stopped", cyc_cnt);
			$display("test failed");
			$finish;
		end
	end

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		word_t rd;
		int    err_before;
		int    txn_before;
		WBs_CLK_i = 1'b0;
		WBs_RST_i <= 1'b1;
		cam       <= '0;
		wb_req    <= '0;
		rng       = 32'h1ea0;    // Fixed seed
		repeat (10) @(posedge WBs_CLK_i);
		WBs_RST_i <= 1'b0;

		err_before = err_cnt;    // 1: reset values
		@(negedge WBs_CLK_i);
		check_equal("qspi_o.nce", 32'(qspi.nce), 32'd1);
		check_equal("qspi_o.oe", 32'(qspi.oe), 32'd1);
		check_equal("qspi_o.dq", 32'(qspi.dq), 32'd0);
		check_equal("wb_ack_o", 32'(wb_ack), 32'd0);
		bus_cycle(1'b0, '0, rd);
		check_equal("wb_dat_o", rd, 32'h0);
		report_test(1, "reset state", err_before);

		err_before = err_cnt;    // 2: enable and read back
		bus_cycle(1'b1, 32'h1, rd);
		bus_cycle(1'b0, '0, rd);
		check_equal("wb_dat_o", rd, 32'h0000_0001);    // Only stream_en set
		report_test(2, "control write and read", err_before);

		err_before = err_cnt;    // 3: two banks streamed
		repeat (4 * 2 * BANK_WORDS) send_byte(BYTE_GAP);
		while (txn_cnt < 2 * BANK_WORDS)
			@(posedge WBs_CLK_i);
		check_equal("queued bytes left", 32'(cam_q.size()), 32'd0);
		report_test(3, "two bank stream", err_before);

		err_before = err_cnt;    // 4: partial word at frame edge
		send_byte(BYTE_GAP);
		send_byte(BYTE_GAP);
		@(posedge WBs_CLK_i);
		cam <= '0;               // vsync low drops the partial word
		repeat (4) @(posedge WBs_CLK_i);
		void'(cam_q.pop_back());
		void'(cam_q.pop_back());
		repeat (4 * BANK_WORDS) send_byte(BYTE_GAP);
		bus_cycle(1'b0, '0, rd);
		check_equal("wb_dat_o", rd, 32'h0000_001d);    // vsync, bank 1, busy, enabled
		while (txn_cnt < 3 * BANK_WORDS)
			@(posedge WBs_CLK_i);
		check_equal("queued bytes left", 32'(cam_q.size()), 32'd0);
		report_test(4, "vsync drop", err_before);

		err_before = err_cnt;    // 5: overrun with streaming off
		bus_cycle(1'b1, 32'h0, rd);
		txn_before = txn_cnt;
		repeat (4 * (2 * BANK_WORDS + 1)) send_byte(2);
		repeat (4) @(posedge WBs_CLK_i);
		bus_cycle(1'b0, '0, rd);
		check_equal("wb_dat_o", rd, 32'h0000_0012);    // vsync and overrun
		check_equal("transactions while disabled", 32'(txn_cnt - txn_before), 32'd0);
		check_equal("qspi_o.nce", 32'(qspi.nce), 32'd1);
		bus_cycle(1'b1, 32'h2, rd);    // Write one to clear
		bus_cycle(1'b0, '0, rd);
		check_equal("wb_dat_o", rd, 32'h0000_0010);    // Only vsync left
		report_test(5, "overrun flag", err_before);

		$display("Summary: 5 tests, %0d with errors, %0d checks, %0d errors",
		         tests_bad, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- wb_status_regs.sv
// Wishbone control and status register
// Bit 0 stream enable, write 1 to bit 1 clears overrun
`timescale 1ns/1ps

module wb_status_regs (
	input  logic                      WBs_CLK_i,        // System clock
	input  logic                      WBs_RST_i,        // Async reset, high
	input  frame_stream_pkg::wb_req_t wb_req_i,         // Host request
	output frame_stream_pkg::word_t   wb_dat_o,         // Read data
	output logic                      wb_ack_o,         // One cycle acknowledge
	input  frame_stream_pkg::status_t status_i,         // Levels from the datapath
	output logic                      stream_en_o,      // Streaming enabled
	output logic                      clr_overrun_o     // Clear strobe
);

	import frame_stream_pkg::*;

	localparam int STAT_BITS = 5;    // Defined read bits

	logic                 ack_nxt;   // Access accepted this cycle
	logic                 wr_acc;    // Accepted write, low byte enabled
	logic [STAT_BITS-1:0] rd_bits;   // Packed read field

	// ------------------------------
	// Access decode
	// ------------------------------
	assign ack_nxt = wb_req_i.cyc & wb_req_i.stb & ~wb_ack_o;
	assign wr_acc  = ack_nxt & wb_req_i.we & wb_req_i.byte_sel[0];

	// ------------------------------
	// Acknowledge and control bits
	// ------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wb_ack_o      <= 1'b0;
			stream_en_o   <= 1'b0;
			clr_overrun_o <= 1'b0;
		end else begin
			wb_ack_o      <= ack_nxt;                    // Exactly one cycle
			clr_overrun_o <= wr_acc & wb_req_i.dat[1];   // Write-one-to-clear
			if (wr_acc)
				stream_en_o <= wb_req_i.dat[0];
		end
	end

	// ------------------------------
	// Read back
	// ------------------------------
	// Bit 0 comes from the local register, not the status echo
	assign rd_bits = {
		status_i.vsync,       // Bit 4
		status_i.fill_bank,   // Bit 3
		status_i.busy,        // Bit 2
		status_i.overrun,     // Bit 1
		stream_en_o           // Bit 0
	};

	assign wb_dat_o = WORD_W'(rd_bits);    // Zeros above

endmodule
